// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = selen_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Testbench failed

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== files.f ====
logic/selen_pkg.sv
logic/wb_com_top.sv
logic/wb_ram.sv
logic/wb_rom.sv
logic/gpio_top.sv
logic/selen_top.sv
testbench/selen_tb.sv

// ==== logic/gpio_top.sv ====
`timescale 1ns/1ps

module gpio_top import selen_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic [WB_AWIDTH-1:0]  wb_adr_i,
	input  logic [WB_DWIDTH-1:0]  wb_dat_i,
	input  logic [WB_SWIDTH-1:0]  wb_sel_i,
	input  logic                  wb_we_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	output logic [WB_DWIDTH-1:0]  wb_dat_o,
	output logic                  wb_ack_o,
	output logic                  wb_err_o,
	input  logic [GPIO_WIDTH-1:0] gpio_pad_i,
	output logic [GPIO_WIDTH-1:0] gpio_pad_o,
	output logic [GPIO_WIDTH-1:0] gpio_padoe_o
);

	logic [WB_AWIDTH-1:0]  reg_off;
	logic                  req;
	logic                  hit_in;
	logic                  hit_out;
	logic                  hit_oe;
	logic                  bad;
	logic [GPIO_WIDTH-1:0] out_q;
	logic [GPIO_WIDTH-1:0] oe_q;
	logic [GPIO_WIDTH-1:0] sync_q;
	logic [GPIO_WIDTH-1:0] in_q;
	logic [GPIO_WIDTH-1:0] rd_sel;
	logic [WB_DWIDTH-1:0]  rd_q;
	logic                  ack_q;
	logic                  err_q;

	// ------------------------------
	// Register decode
	// ------------------------------
	assign reg_off = wb_adr_i & GPIO_MASK;
	assign hit_in  = reg_off == RGPIO_IN;
	assign hit_out = reg_off == RGPIO_OUT;
	assign hit_oe  = reg_off == RGPIO_OE;
	// Input register is read only
	assign bad = ~(hit_in | hit_out | hit_oe) | (hit_in & wb_we_i);
	assign req = wb_cyc_i & wb_stb_i & ~ack_q & ~err_q;

	always_comb begin
		rd_sel = in_q;
		if (hit_out)
			rd_sel = out_q;
		else if (hit_oe)
			rd_sel = oe_q;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			out_q <= '0;
			oe_q  <= '0;
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= req & ~bad;
			err_q <= req & bad;
			if (req && !bad && wb_we_i && wb_sel_i[0]) begin
				if (hit_out)
					out_q <= wb_dat_i[GPIO_WIDTH-1:0];
				if (hit_oe)
					oe_q <= wb_dat_i[GPIO_WIDTH-1:0];
			end
		end
	end

	// Pad synchronizer and read data
	always_ff @(posedge clk) begin
		sync_q <= gpio_pad_i;
		in_q   <= sync_q;
		if (req)
			rd_q <= {{(WB_DWIDTH-GPIO_WIDTH){1'b0}}, rd_sel};
	end

	assign wb_dat_o     = rd_q;
	assign wb_ack_o     = ack_q;
	assign wb_err_o     = err_q;
	assign gpio_pad_o   = out_q;
	assign gpio_padoe_o = oe_q;

endmodule

// ==== logic/selen_pkg.sv ====
package selen_pkg;

	// ------------------------------
	// Bus widths
	// ------------------------------
	localparam int WB_AWIDTH = 32;
	localparam int WB_DWIDTH = 32;
	localparam int WB_SWIDTH = WB_DWIDTH / 8;

	// ------------------------------
	// Memories
	// ------------------------------
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = $clog2(RAM_WORDS);
	localparam int ROM_WORDS = 32;
	localparam int ROM_AW    = $clog2(ROM_WORDS);
	localparam     ROM_FILE  = "selen_rom.hex";

	localparam int GPIO_WIDTH = 8;

	// ------------------------------
	// Address map
	// ------------------------------
	// Top level split
	localparam logic [WB_AWIDTH-1:0] IO_BASE  = 32'h0000_0000;
	localparam logic [WB_AWIDTH-1:0] IO_MASK  = 32'h0000_3fff;
	localparam logic [WB_AWIDTH-1:0] RAM_BASE = 32'h0010_0000;
	localparam logic [WB_AWIDTH-1:0] RAM_MASK = 32'h0000_0fff;

	// Inside the I/O region
	localparam logic [WB_AWIDTH-1:0] ROM_BASE  = 32'h0000_0000;
	localparam logic [WB_AWIDTH-1:0] ROM_MASK  = 32'h0000_0fff;
	localparam logic [WB_AWIDTH-1:0] GPIO_BASE = 32'h0000_2000;
	localparam logic [WB_AWIDTH-1:0] GPIO_MASK = 32'h0000_0fff;

	// GPIO register offsets
	localparam logic [WB_AWIDTH-1:0] RGPIO_IN  = 32'h0000_0000;
	localparam logic [WB_AWIDTH-1:0] RGPIO_OUT = 32'h0000_0004;
	localparam logic [WB_AWIDTH-1:0] RGPIO_OE  = 32'h0000_0008;

endpackage

// ==== logic/selen_top.sv ====
`timescale 1ns/1ps

module selen_top import selen_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic [WB_AWIDTH-1:0]  wb_adr_i,
	input  logic [WB_DWIDTH-1:0]  wb_dat_i,
	input  logic [WB_SWIDTH-1:0]  wb_sel_i,
	input  logic                  wb_we_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	output logic [WB_DWIDTH-1:0]  wb_dat_o,
	output logic                  wb_ack_o,
	output logic                  wb_err_o,
	input  logic [GPIO_WIDTH-1:0] gpio_pad_i,
	output logic [GPIO_WIDTH-1:0] gpio_pad_o,
	output logic [GPIO_WIDTH-1:0] gpio_padoe_o
);

	// ------------------------------
	// Bus wires named by the slave side
	// ------------------------------
	logic [WB_AWIDTH-1:0] io_adr;
	logic [WB_DWIDTH-1:0] io_wdat;
	logic [WB_DWIDTH-1:0] io_rdat;
	logic [WB_SWIDTH-1:0] io_sel;
	logic                 io_we;
	logic                 io_cyc;
	logic                 io_stb;
	logic                 io_ack;
	logic                 io_err;

	logic [WB_AWIDTH-1:0] ram_adr;
	logic [WB_DWIDTH-1:0] ram_wdat;
	logic [WB_DWIDTH-1:0] ram_rdat;
	logic [WB_SWIDTH-1:0] ram_sel;
	logic                 ram_we;
	logic                 ram_cyc;
	logic                 ram_stb;
	logic                 ram_ack;
	logic                 ram_err;

	logic [WB_AWIDTH-1:0] rom_adr;
	logic [WB_DWIDTH-1:0] rom_wdat;
	logic [WB_DWIDTH-1:0] rom_rdat;
	logic [WB_SWIDTH-1:0] rom_sel;
	logic                 rom_we;
	logic                 rom_cyc;
	logic                 rom_stb;
	logic                 rom_ack;
	logic                 rom_err;

	logic [WB_AWIDTH-1:0] gpio_adr;
	logic [WB_DWIDTH-1:0] gpio_wdat;
	logic [WB_DWIDTH-1:0] gpio_rdat;
	logic [WB_SWIDTH-1:0] gpio_sel;
	logic                 gpio_we;
	logic                 gpio_cyc;
	logic                 gpio_stb;
	logic                 gpio_ack;
	logic                 gpio_err;

	// I/O region on slave 0, RAM on slave 1
	wb_com_top #(
		.S0_ADDR_BASE(IO_BASE),
		.S0_ADDR_MASK(IO_MASK),
		.S1_ADDR_BASE(RAM_BASE),
		.S1_ADDR_MASK(RAM_MASK)
	) cpu_xbar (
		.clk      (clk),
		.reset_i  (reset_i),
		.m_adr_i  (wb_adr_i),
		.m_dat_i  (wb_dat_i),
		.m_sel_i  (wb_sel_i),
		.m_we_i   (wb_we_i),
		.m_cyc_i  (wb_cyc_i),
		.m_stb_i  (wb_stb_i),
		.m_dat_o  (wb_dat_o),
		.m_ack_o  (wb_ack_o),
		.m_err_o  (wb_err_o),
		.s0_adr_o (io_adr),
		.s0_dat_o (io_wdat),
		.s0_sel_o (io_sel),
		.s0_we_o  (io_we),
		.s0_cyc_o (io_cyc),
		.s0_stb_o (io_stb),
		.s0_dat_i (io_rdat),
		.s0_ack_i (io_ack),
		.s0_err_i (io_err),
		.s1_adr_o (ram_adr),
		.s1_dat_o (ram_wdat),
		.s1_sel_o (ram_sel),
		.s1_we_o  (ram_we),
		.s1_cyc_o (ram_cyc),
		.s1_stb_o (ram_stb),
		.s1_dat_i (ram_rdat),
		.s1_ack_i (ram_ack),
		.s1_err_i (ram_err)
	);

	wb_com_top #(
		.S0_ADDR_BASE(ROM_BASE),
		.S0_ADDR_MASK(ROM_MASK),
		.S1_ADDR_BASE(GPIO_BASE),
		.S1_ADDR_MASK(GPIO_MASK)
	) perif_xbar (
		.clk      (clk),
		.reset_i  (reset_i),
		.m_adr_i  (io_adr),
		.m_dat_i  (io_wdat),
		.m_sel_i  (io_sel),
		.m_we_i   (io_we),
		.m_cyc_i  (io_cyc),
		.m_stb_i  (io_stb),
		.m_dat_o  (io_rdat),
		.m_ack_o  (io_ack),
		.m_err_o  (io_err),
		.s0_adr_o (rom_adr),
		.s0_dat_o (rom_wdat),
		.s0_sel_o (rom_sel),
		.s0_we_o  (rom_we),
		.s0_cyc_o (rom_cyc),
		.s0_stb_o (rom_stb),
		.s0_dat_i (rom_rdat),
		.s0_ack_i (rom_ack),
		.s0_err_i (rom_err),
		.s1_adr_o (gpio_adr),
		.s1_dat_o (gpio_wdat),
		.s1_sel_o (gpio_sel),
		.s1_we_o  (gpio_we),
		.s1_cyc_o (gpio_cyc),
		.s1_stb_o (gpio_stb),
		.s1_dat_i (gpio_rdat),
		.s1_ack_i (gpio_ack),
		.s1_err_i (gpio_err)
	);

	wb_ram ram_inst (
		.clk      (clk),
		.reset_i  (reset_i),
		.wb_adr_i (ram_adr),
		.wb_dat_i (ram_wdat),
		.wb_sel_i (ram_sel),
		.wb_we_i  (ram_we),
		.wb_cyc_i (ram_cyc),
		.wb_stb_i (ram_stb),
		.wb_dat_o (ram_rdat),
		.wb_ack_o (ram_ack),
		.wb_err_o (ram_err)
	);

	wb_rom rom_inst (
		.clk      (clk),
		.reset_i  (reset_i),
		.wb_adr_i (rom_adr),
		.wb_dat_i (rom_wdat),
		.wb_sel_i (rom_sel),
		.wb_we_i  (rom_we),
		.wb_cyc_i (rom_cyc),
		.wb_stb_i (rom_stb),
		.wb_dat_o (rom_rdat),
		.wb_ack_o (rom_ack),
		.wb_err_o (rom_err)
	);

	gpio_top gpio_inst (
		.clk          (clk),
		.reset_i      (reset_i),
		.wb_adr_i     (gpio_adr),
		.wb_dat_i     (gpio_wdat),
		.wb_sel_i     (gpio_sel),
		.wb_we_i      (gpio_we),
		.wb_cyc_i     (gpio_cyc),
		.wb_stb_i     (gpio_stb),
		.wb_dat_o     (gpio_rdat),
		.wb_ack_o     (gpio_ack),
		.wb_err_o     (gpio_err),
		.gpio_pad_i   (gpio_pad_i),
		.gpio_pad_o   (gpio_pad_o),
		.gpio_padoe_o (gpio_padoe_o)
	);

endmodule

// ==== logic/wb_com_top.sv ====
`timescale 1ns/1ps

module wb_com_top import selen_pkg::*; #(
	parameter logic [WB_AWIDTH-1:0] S0_ADDR_BASE = IO_BASE,
	parameter logic [WB_AWIDTH-1:0] S0_ADDR_MASK = IO_MASK,
	parameter logic [WB_AWIDTH-1:0] S1_ADDR_BASE = RAM_BASE,
	parameter logic [WB_AWIDTH-1:0] S1_ADDR_MASK = RAM_MASK
) (
	input  logic                 clk,
	input  logic                 reset_i,
	// Master side
	input  logic [WB_AWIDTH-1:0] m_adr_i,
	input  logic [WB_DWIDTH-1:0] m_dat_i,
	input  logic [WB_SWIDTH-1:0] m_sel_i,
	input  logic                 m_we_i,
	input  logic                 m_cyc_i,
	input  logic                 m_stb_i,
	output logic [WB_DWIDTH-1:0] m_dat_o,
	output logic                 m_ack_o,
	output logic                 m_err_o,
	// Slave 0
	output logic [WB_AWIDTH-1:0] s0_adr_o,
	output logic [WB_DWIDTH-1:0] s0_dat_o,
	output logic [WB_SWIDTH-1:0] s0_sel_o,
	output logic                 s0_we_o,
	output logic                 s0_cyc_o,
	output logic                 s0_stb_o,
	input  logic [WB_DWIDTH-1:0] s0_dat_i,
	input  logic                 s0_ack_i,
	input  logic                 s0_err_i,
	// Slave 1
	output logic [WB_AWIDTH-1:0] s1_adr_o,
	output logic [WB_DWIDTH-1:0] s1_dat_o,
	output logic [WB_SWIDTH-1:0] s1_sel_o,
	output logic                 s1_we_o,
	output logic                 s1_cyc_o,
	output logic                 s1_stb_o,
	input  logic [WB_DWIDTH-1:0] s1_dat_i,
	input  logic                 s1_ack_i,
	input  logic                 s1_err_i
);

	logic s0_hit;
	logic s1_hit;
	logic m_req;
	logic miss_err_q;

	assign s0_hit = (m_adr_i & ~S0_ADDR_MASK) == S0_ADDR_BASE;
	assign s1_hit = (m_adr_i & ~S1_ADDR_MASK) == S1_ADDR_BASE;
	assign m_req  = m_cyc_i & m_stb_i;

	// Payload goes to both, the strobe only to the selected one
	assign s0_adr_o = m_adr_i;
	assign s0_dat_o = m_dat_i;
	assign s0_sel_o = m_sel_i;
	assign s0_we_o  = m_we_i;
	assign s0_cyc_o = m_cyc_i & s0_hit;
	assign s0_stb_o = m_stb_i & s0_hit;

	assign s1_adr_o = m_adr_i;
	assign s1_dat_o = m_dat_i;
	assign s1_sel_o = m_sel_i;
	assign s1_we_o  = m_we_i;
	assign s1_cyc_o = m_cyc_i & s1_hit;
	assign s1_stb_o = m_stb_i & s1_hit;

	assign m_dat_o = s1_hit ? s1_dat_i : s0_dat_i;
	assign m_ack_o = (s0_hit & s0_ack_i) | (s1_hit & s1_ack_i);
	assign m_err_o = (s0_hit & s0_err_i) | (s1_hit & s1_err_i) | miss_err_q;

	// Unmapped address answered once per strobe
	always_ff @(posedge clk) begin
		if (reset_i)
			miss_err_q <= 1'b0;
		else
			miss_err_q <= m_req & ~s0_hit & ~s1_hit & ~miss_err_q;
	end

	assert property (@(posedge clk) disable iff (reset_i) m_req |-> !(s0_hit && s1_hit));

	// No slave may answer a strobe the decoder has already refused
	assert property (@(posedge clk) disable iff (reset_i)
		miss_err_q |-> !(s0_ack_i || s1_ack_i));

endmodule

// ==== logic/wb_ram.sv ====
`timescale 1ns/1ps

module wb_ram import selen_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic [WB_AWIDTH-1:0] wb_adr_i,
	input  logic [WB_DWIDTH-1:0] wb_dat_i,
	input  logic [WB_SWIDTH-1:0] wb_sel_i,
	input  logic                 wb_we_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	output logic [WB_DWIDTH-1:0] wb_dat_o,
	output logic                 wb_ack_o,
	output logic                 wb_err_o
);

	logic [WB_DWIDTH-1:0] mem [RAM_WORDS];
	logic [RAM_AW-1:0]    word_idx;
	logic                 req;
	logic [WB_DWIDTH-1:0] rd_q;
	logic                 ack_q;
	logic                 err_q;

	assign word_idx = wb_adr_i[RAM_AW+1:2];
	// Strobe stays up during the response cycle
	assign req = wb_cyc_i & wb_stb_i & ~ack_q & ~err_q;

	always_ff @(posedge clk) begin
		if (req && wb_we_i) begin
			for (int b = 0; b < WB_SWIDTH; b++) begin
				if (wb_sel_i[b])
					mem[word_idx][b*8 +: 8] <= wb_dat_i[b*8 +: 8];
			end
		end
		if (req)
			rd_q <= mem[word_idx];
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= req & (|wb_sel_i);
			err_q <= req & ~(|wb_sel_i);
		end
	end

	assign wb_dat_o = rd_q;
	assign wb_ack_o = ack_q;
	assign wb_err_o = err_q;

	// Master still holds the same request while ack is up
	assert property (@(posedge clk) disable iff (reset_i)
		wb_ack_o |-> wb_cyc_i && wb_stb_i && $stable(wb_adr_i));

endmodule

// ==== logic/wb_rom.sv ====
`timescale 1ns/1ps

module wb_rom import selen_pkg::*; (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic [WB_AWIDTH-1:0] wb_adr_i,
	input  logic [WB_DWIDTH-1:0] wb_dat_i,
	input  logic [WB_SWIDTH-1:0] wb_sel_i,
	input  logic                 wb_we_i,
	input  logic                 wb_cyc_i,
	input  logic                 wb_stb_i,
	output logic [WB_DWIDTH-1:0] wb_dat_o,
	output logic                 wb_ack_o,
	output logic                 wb_err_o
);

	logic [WB_DWIDTH-1:0] rom [ROM_WORDS];
	logic                 req;
	logic [WB_DWIDTH-1:0] rd_q;
	logic                 ack_q;
	logic                 err_q;

	initial $readmemh(ROM_FILE, rom);

	assign req = wb_cyc_i & wb_stb_i & ~ack_q & ~err_q;

	// Index drops the upper bits, so the image repeats in the window
	always_ff @(posedge clk) begin
		if (req)
			rd_q <= rom[wb_adr_i[ROM_AW+1:2]];
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= req & ~wb_we_i;
			err_q <= req & wb_we_i;
		end
	end

	assign wb_dat_o = rd_q;
	assign wb_ack_o = ack_q;
	assign wb_err_o = err_q;

	// Response only while the master still holds the same request
	assert property (@(posedge clk) disable iff (reset_i)
		(wb_ack_o || wb_err_o) |-> wb_cyc_i && wb_stb_i && $stable(wb_adr_i));

endmodule

// ==== selen_rom.hex ====
// One 32-bit ROM word per line in hex, word address 0 at the top
// 32 words in total
00000013
3c1a0010
8f5b2204
27bdfff0
afbf000c
0c0000a5
a5a5a5a5
5a5a5a5a
deadbeef
c001d00d
01234567
89abcdef
fedcba98
76543210
00ff00ff
ff00ff00
13579bdf
2468ace0
0f1e2d3c
4b5a6978
87961a2b
3c4d5e6f
70819203
b4c5d6e7
f8091a2b
12345678
9abcdef0
55aa33cc
cc33aa55
80000001
7ffffffe
e1d2c3b4

// ==== testbench/selen_tb.sv ====
`timescale 1ns/1ps

module selen_tb import selen_pkg::*; ();

	localparam int N_ACCESSES     = 248;
	localparam int TIMEOUT_CYCLES = N_ACCESSES * 4 + 200;
	localparam int RESP_LIMIT     = 8;
	localparam int PAD_ZEROS      = WB_DWIDTH - GPIO_WIDTH;

	logic                  clk;
	logic                  reset_i;
	logic [WB_AWIDTH-1:0]  wb_adr_i;
	logic [WB_DWIDTH-1:0]  wb_dat_i;
	logic [WB_SWIDTH-1:0]  wb_sel_i;
	logic                  wb_we_i;
	logic                  wb_cyc_i;
	logic                  wb_stb_i;
	logic [WB_DWIDTH-1:0]  wb_dat_o;
	logic                  wb_ack_o;
	logic                  wb_err_o;
	logic [GPIO_WIDTH-1:0] gpio_pad_i;
	logic [GPIO_WIDTH-1:0] gpio_pad_o;
	logic [GPIO_WIDTH-1:0] gpio_padoe_o;

	// Reference model state
	logic [WB_DWIDTH-1:0]  ram_img [RAM_WORDS];
	logic [WB_DWIDTH-1:0]  rom_img [ROM_WORDS];
	logic [GPIO_WIDTH-1:0] out_model;
	logic [GPIO_WIDTH-1:0] oe_model;
	logic [GPIO_WIDTH-1:0] pad_model;

	// Request in flight
	logic                 pending;
	logic                 exp_err;
	logic                 exp_we;
	logic [WB_DWIDTH-1:0] exp_dat;
	int                   req_cycle;

	string  cur_test;
	integer seed;
	int     cycle_cnt    = 0;
	int     n_checked    = 0;
	int     value_errors = 0;
	int     resp_errors  = 0;
	int     proto_errors = 0;

	selen_top selen_top_inst (
		.clk          (clk),
		.reset_i      (reset_i),
		.wb_adr_i     (wb_adr_i),
		.wb_dat_i     (wb_dat_i),
		.wb_sel_i     (wb_sel_i),
		.wb_we_i      (wb_we_i),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o),
		.wb_err_o     (wb_err_o),
		.gpio_pad_i   (gpio_pad_i),
		.gpio_pad_o   (gpio_pad_o),
		.gpio_padoe_o (gpio_padoe_o)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic logic [WB_DWIDTH-1:0] zext(input logic [GPIO_WIDTH-1:0] v);
		return {{PAD_ZEROS{1'b0}}, v};
	endfunction

	// Returns {err, read data} for one access
	function automatic logic [WB_DWIDTH:0] predict(input logic [WB_AWIDTH-1:0] adr,
			input logic we, input logic [WB_SWIDTH-1:0] sel);
		logic [WB_AWIDTH-1:0] off;
		logic [WB_DWIDTH:0]   res;
		res = {1'b1, {WB_DWIDTH{1'b0}}};
		if ((adr & ~RAM_MASK) == RAM_BASE) begin
			if (sel != '0)
				res = {1'b0, ram_img[adr[RAM_AW+1:2]]};
		end else if ((adr & ~IO_MASK) == IO_BASE) begin
			if ((adr & ~ROM_MASK) == ROM_BASE) begin
				if (!we)
					res = {1'b0, rom_img[adr[ROM_AW+1:2]]};
			end else if ((adr & ~GPIO_MASK) == GPIO_BASE) begin
				off = adr & GPIO_MASK;
				if (off == RGPIO_IN && !we)
					res = {1'b0, zext(pad_model)};
				else if (off == RGPIO_OUT)
					res = {1'b0, zext(out_model)};
				else if (off == RGPIO_OE)
					res = {1'b0, zext(oe_model)};
			end
		end
		return res;
	endfunction

	// Only called for writes the model expects to be acked
	function automatic void model_write(input logic [WB_AWIDTH-1:0] adr,
			input logic [WB_DWIDTH-1:0] dat, input logic [WB_SWIDTH-1:0] sel);
		int b;
		if ((adr & ~RAM_MASK) == RAM_BASE) begin
			for (b = 0; b < WB_SWIDTH; b++) begin
				if (sel[b])
					ram_img[adr[RAM_AW+1:2]][b*8 +: 8] = dat[b*8 +: 8];
			end
		end else if ((adr & ~GPIO_MASK) == GPIO_BASE && sel[0]) begin
			if ((adr & GPIO_MASK) == RGPIO_OUT)
				out_model = dat[GPIO_WIDTH-1:0];
			else if ((adr & GPIO_MASK) == RGPIO_OE)
				oe_model = dat[GPIO_WIDTH-1:0];
		end
	endfunction

	task automatic check_value(input string name, input logic [WB_DWIDTH-1:0] exp,
			input logic [WB_DWIDTH-1:0] act);
		assert (act === exp) else begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	// ------------------------------
	// Bus master
	// ------------------------------
	task automatic transfer(input logic [WB_AWIDTH-1:0] adr, input logic [WB_DWIDTH-1:0] dat,
			input logic [WB_SWIDTH-1:0] sel, input logic we);
		logic [WB_DWIDTH:0] pred;
		int                 waited;
		pred = predict(adr, we, sel);
		if (we && !pred[WB_DWIDTH])
			model_write(adr, dat, sel);
		@(posedge clk);
		#1;
		exp_err   = pred[WB_DWIDTH];
		exp_dat   = pred[WB_DWIDTH-1:0];
		exp_we    = we;
		req_cycle = cycle_cnt;
		pending   = 1'b1;
		wb_adr_i  = adr;
		wb_dat_i  = dat;
		wb_sel_i  = sel;
		wb_we_i   = we;
		wb_cyc_i  = 1'b1;
		wb_stb_i  = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!(wb_ack_o || wb_err_o) && waited < RESP_LIMIT);
		assert (wb_ack_o || wb_err_o) else begin
			$display("No response from the bus in %s at address %h", cur_test, adr);
			proto_errors++;
			pending = 1'b0;
		end
		@(posedge clk);
		#1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
	endtask

	task automatic write_word(input logic [WB_AWIDTH-1:0] adr, input logic [WB_DWIDTH-1:0] dat,
			input logic [WB_SWIDTH-1:0] sel);
		transfer(adr, dat, sel, 1'b1);
	endtask

	task automatic read_word(input logic [WB_AWIDTH-1:0] adr);
		transfer(adr, '0, '1, 1'b0);
	endtask

	task automatic finish_run();
		int total;
		total = value_errors + resp_errors + proto_errors;
		$display("Checked %0d responses: %0d data errors, %0d response errors, %0d protocol errors",
			n_checked, value_errors, resp_errors, proto_errors);
		if (total == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	// ------------------------------
	// Response checker
	// ------------------------------
	always @(negedge clk) begin
		if (wb_ack_o || wb_err_o) begin
			assert (pending) else begin
				$display("Response seen with no request outstanding at cycle %0d", cycle_cnt);
				proto_errors++;
			end
			if (pending) begin
				n_checked++;
				assert (!(wb_ack_o && wb_err_o)) else begin
					$display("ack and err were high together in %s", cur_test);
					proto_errors++;
				end
				assert (cycle_cnt == req_cycle + 1) else begin
					$display("[ERROR] %s latency: expected %0d, actual %0d",
						cur_test, 1, cycle_cnt - req_cycle);
					resp_errors++;
				end
				assert (wb_err_o == exp_err) else begin
					$display("[ERROR] %s response: expected %s, actual %s", cur_test,
						exp_err ? "err" : "ack", wb_err_o ? "err" : "ack");
					resp_errors++;
				end
				if (!exp_err && !exp_we && wb_ack_o)
					check_value(cur_test, exp_dat, wb_dat_o);
				pending = 1'b0;
			end
		end
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES)
			@(posedge clk);
		$display("Timeout after %0d cycles, the test sequence did not finish", TIMEOUT_CYCLES);
		proto_errors++;
		finish_run();
	end

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		int          i;
		int          k;
		logic [31:0] rnd;
		logic [31:0] dat;
		clk        = 1'b0;
		reset_i    = 1'b1;
		wb_adr_i   = '0;
		wb_dat_i   = '0;
		wb_sel_i   = '0;
		wb_we_i    = 1'b0;
		wb_cyc_i   = 1'b0;
		wb_stb_i   = 1'b0;
		gpio_pad_i = '0;
		pending    = 1'b0;
		exp_err    = 1'b0;
		exp_we     = 1'b0;
		exp_dat    = '0;
		req_cycle  = 0;
		out_model  = '0;
		oe_model   = '0;
		pad_model  = '0;
		seed       = 40429;
		cur_test   = "reset";
		$readmemh("selen_rom.hex", rom_img);
		repeat (16) @(posedge clk);
		#1;
		reset_i = 1'b0;
		check_value("gpio_padoe_reset", '0, zext(gpio_padoe_o));

		// Known contents first, so partial writes merge into defined bytes
		cur_test = "ram_fill";
		for (i = 0; i < 64; i++) begin
			rnd = $random(seed);
			write_word(RAM_BASE + i * 16, rnd, 4'hf);
		end
		cur_test = "ram_random";
		for (i = 0; i < 64; i++) begin
			rnd = $random(seed);
			dat = $random(seed);
			write_word(RAM_BASE + {22'h0, rnd[5:0], 4'h0}, dat, rnd[11:8]);
		end
		cur_test = "ram_readback";
		for (i = 0; i < 64; i++) begin
			k = (i * 29) % 64;
			read_word(RAM_BASE + k * 16);
		end

		cur_test = "rom_read";
		for (i = 0; i < ROM_WORDS; i++)
			read_word(ROM_BASE + i * 4);
		cur_test = "rom_write";
		write_word(ROM_BASE + 32'h8, 32'hdead_beef, 4'hf);
		read_word(ROM_BASE + 32'h8);

		cur_test = "gpio_out";
		for (i = 0; i < 2; i++) begin
			rnd = $random(seed);
			write_word(GPIO_BASE + RGPIO_OUT, rnd, 4'h1);
			write_word(GPIO_BASE + RGPIO_OE, {rnd[7:0], rnd[31:8]}, 4'h1);
			check_value("gpio_pad_o", zext(out_model), zext(gpio_pad_o));
			check_value("gpio_padoe_o", zext(oe_model), zext(gpio_padoe_o));
			read_word(GPIO_BASE + RGPIO_OUT);
			read_word(GPIO_BASE + RGPIO_OE);
		end
		// Register keeps its value without byte 0 selected
		write_word(GPIO_BASE + RGPIO_OUT, 32'h0000_5a00, 4'h2);
		read_word(GPIO_BASE + RGPIO_OUT);

		cur_test = "gpio_in";
		for (i = 0; i < 8; i++) begin
			@(posedge clk);
			#1;
			rnd = $random(seed);
			gpio_pad_i = rnd[GPIO_WIDTH-1:0];
			pad_model  = rnd[GPIO_WIDTH-1:0];
			repeat (3) @(posedge clk);
			read_word(GPIO_BASE + RGPIO_IN);
		end

		cur_test = "unmapped";
		read_word(32'h0000_1000);
		write_word(32'h0020_0000, 32'h1234_5678, 4'hf);
		cur_test = "gpio_err";
		read_word(GPIO_BASE + 32'h0000_000c);
		write_word(GPIO_BASE + RGPIO_IN, 32'h0000_00ff, 4'h1);

		finish_run();
	end

endmodule
